/* sources.f */
ahb_stream_pkg.sv
stream_fifo.sv
axis2ahb.sv
ahb_sram.sv
ahb_stream_top.sv
ahb_stream_assertions.sv
tb_ahb_stream.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the bridge regression with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ahb_stream -f sources.f

./obj_dir/Vtb_ahb_stream +verilator+error+limit+1000 | tee sim.log

if grep -q "Regression failed" sim.log; then
   exit 1
fi
exit 0

/* tb_ahb_stream.sv */
`timescale 1ns/10ps
// ========================================
// drives the bridge through write, read, stall and wrap cases
// model tracks only the words this bench writes
// ========================================
module tb_ahb_stream
   import ahb_stream_pkg::*;
;

   // word count over all tests sets the cycle budget
   localparam int TEST_WORDS  = 77;
   localparam int CYCLE_LIMIT = TEST_WORDS * (WAIT_STATES + 3) + 200;

   logic              clk_i;
   logic              rst_i;
   logic              cfg_wr_valid_i;
   logic [ADDR_W-1:0] cfg_wr_addr_i;
   logic              cfg_wr_ready_o;
   logic              cfg_rd_valid_i;
   logic [ADDR_W-1:0] cfg_rd_addr_i;
   logic [LEN_W-1:0]  cfg_rd_len_i;
   logic              cfg_rd_ready_o;
   logic              in_tvalid_i;
   logic [DATA_W-1:0] in_tdata_i;
   logic              in_tlast_i;
   logic              in_tready_o;
   logic              out_tvalid_o;
   logic [DATA_W-1:0] out_tdata_o;
   logic              out_tlast_o;
   logic              out_tready_i;

   logic [DATA_W-1:0] model_mem [MEM_WORDS];
   logic [31:0]       lfsr_state;
   int                errors;
   int                cycles;

   ahb_stream_top uut (.*);

   bind axis2ahb ahb_stream_assertions chk (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .cfg_wr_ready_i(cfg_wr_ready_o),
      .cfg_rd_ready_i(cfg_rd_ready_o),
      .hahb_addr_i   (hahb_addr_o),
      .hahb_trans_i  (hahb_trans_o),
      .hahb_ready_i  (hahb_ready_i),
      .s_tvalid_i    (s_tvalid_i),
      .s_tdata_i     (s_tdata_i),
      .s_tlast_i     (s_tlast_i),
      .s_tready_i    (s_tready_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   // galois form with taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic next_random_bit();
      logic bit_out;
      bit_out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (bit_out) begin
         lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      return bit_out;
   endfunction

   function automatic logic [DATA_W-1:0] random_word();
      logic [DATA_W-1:0] w;
      for (int i = 0; i < DATA_W; i++) begin
         w[i] = next_random_bit();
      end
      return w;
   endfunction

   // memory index of a word modulo the depth
   function automatic logic [MEM_AW-1:0] word_index(input logic [ADDR_W-1:0] base,
                                                    input int offset);
      return MEM_AW'((int'(base / ADDR_STEP) + offset) % MEM_WORDS);
   endfunction

   task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
      assert (actual === expected) else begin
         errors++;
         $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   // starts and ends at a falling edge
   task automatic send_burst(input string name, input logic [ADDR_W-1:0] base, input int n,
                             input bit gaps, input bit read_held);
      int sent;
      bit fire;
      cfg_wr_valid_i = 1'b1;
      cfg_wr_addr_i  = base;
      do begin
         @(posedge clk_i);
         if (read_held) begin
            check_value({name, " cfg_rd_ready"}, '0, DATA_W'(cfg_rd_ready_o));
         end
      end while (!cfg_wr_ready_o);
      @(negedge clk_i);
      cfg_wr_valid_i = 1'b0;
      sent = 0;
      while (sent < n) begin
         if (!in_tvalid_i && !(gaps && next_random_bit())) begin
            in_tvalid_i = 1'b1;
            in_tdata_i  = random_word();
            in_tlast_i  = (sent == n - 1);
         end
         @(posedge clk_i);
         if (read_held) begin
            check_value({name, " cfg_rd_ready"}, '0, DATA_W'(cfg_rd_ready_o));
         end
         fire = in_tvalid_i && in_tready_o;
         if (fire) begin
            model_mem[word_index(base, sent)] = in_tdata_i;
            sent++;
         end
         @(negedge clk_i);
         if (fire) begin
            in_tvalid_i = 1'b0;
            in_tlast_i  = 1'b0;
         end
      end
   endtask

   task automatic fetch_check(input string name, input logic [ADDR_W-1:0] base, input int len,
                              input bit gaps);
      int got;
      cfg_rd_valid_i = 1'b1;
      cfg_rd_addr_i  = base;
      cfg_rd_len_i   = LEN_W'(len);
      do @(posedge clk_i); while (!cfg_rd_ready_o);
      @(negedge clk_i);
      cfg_rd_valid_i = 1'b0;
      got = 0;
      while (got < len) begin
         out_tready_i = gaps ? next_random_bit() : 1'b1;
         @(posedge clk_i);
         if (out_tvalid_o && out_tready_i) begin
            check_value({name, " data"}, model_mem[word_index(base, got)], out_tdata_o);
            check_value({name, " last"}, DATA_W'(got == len - 1), DATA_W'(out_tlast_o));
            got++;
         end
         @(negedge clk_i);
      end
      // nothing may follow the final word
      out_tready_i = 1'b1;
      repeat (3) begin
         @(posedge clk_i);
         check_value({name, " extra word"}, '0, DATA_W'(out_tvalid_o));
         @(negedge clk_i);
      end
      out_tready_i = 1'b0;
   endtask

   task automatic finish_run();
      $display("closing: %0d errors, %0d assertion failures", errors,
               uut.adapter.chk.fail_count);
      if (errors == 0 && uut.adapter.chk.fail_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   endtask

   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk_i);
         cycles++;
      end
      errors++;
      $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      finish_run();
   end

   initial begin
      rst_i          = 1'b1;
      cfg_wr_valid_i = 1'b0;
      cfg_wr_addr_i  = '0;
      cfg_rd_valid_i = 1'b0;
      cfg_rd_addr_i  = '0;
      cfg_rd_len_i   = '0;
      in_tvalid_i    = 1'b0;
      in_tdata_i     = '0;
      in_tlast_i     = 1'b0;
      out_tready_i   = 1'b0;
      lfsr_state     = 32'h9ba6_b1e2;
      errors         = 0;
      repeat (2) @(negedge clk_i);
      rst_i = 1'b0;
      repeat (3) begin
         @(posedge clk_i);
         check_value("reset out_tvalid", '0, DATA_W'(out_tvalid_o));
         check_value("reset cfg_wr_ready", '0, DATA_W'(cfg_wr_ready_o));
         check_value("reset cfg_rd_ready", '0, DATA_W'(cfg_rd_ready_o));
         check_value("reset in_tready", DATA_W'(1), DATA_W'(in_tready_o));
      end
      @(negedge clk_i);
      send_burst("write readback", 32'h10, 8, 1'b0, 1'b0);
      fetch_check("write readback", 32'h10, 8, 1'b0);
      send_burst("input stalls", 32'h40, 12, 1'b1, 1'b0);
      fetch_check("input stalls", 32'h40, 12, 1'b0);
      fetch_check("output back-pressure", 32'h40, 12, 1'b1);
      // read offered together with the write
      cfg_rd_valid_i = 1'b1;
      cfg_rd_addr_i  = 32'h84;
      cfg_rd_len_i   = LEN_W'(1);
      send_burst("priority", 32'h80, 4, 1'b0, 1'b1);
      fetch_check("single read", 32'h84, 1, 1'b0);
      send_burst("address wrap", 32'hF0, 8, 1'b1, 1'b0);
      fetch_check("address wrap", 32'h0, 12, 1'b1);
      finish_run();
   end

endmodule

/* ahb_stream_assertions.sv */
`timescale 1ns/10ps
// ========================================
// protocol checks on the bridge's AHB side
// and on the stream feeding the adapter
// ========================================
module ahb_stream_assertions
   import ahb_stream_pkg::*;
(
   input logic              clk_i,
   input logic              rst_i,
   input logic              cfg_wr_ready_i,
   input logic              cfg_rd_ready_i,
   input logic [ADDR_W-1:0] hahb_addr_i,
   input logic [1:0]        hahb_trans_i,
   input logic              hahb_ready_i,
   input logic              s_tvalid_i,
   input logic [DATA_W-1:0] s_tdata_i,
   input logic              s_tlast_i,
   input logic              s_tready_i
);

   int unsigned fail_count = 0;

   // address phase held through wait states
   addr_held: assert property (@(posedge clk_i) disable iff (rst_i)
      !hahb_ready_i |=> $stable(hahb_addr_i) && $stable(hahb_trans_i))
   else begin
      fail_count++;
      $error("address or transfer type changed while ready was low");
   end

   no_busy_after_idle: assert property (@(posedge clk_i) disable iff (rst_i)
      hahb_trans_i == TRANS_IDLE |=> hahb_trans_i != TRANS_BUSY)
   else begin
      fail_count++;
      $error("BUSY transfer directly after IDLE");
   end

   // offered beat waits unchanged until taken
   stream_held: assert property (@(posedge clk_i) disable iff (rst_i)
      s_tvalid_i && !s_tready_i |=> s_tvalid_i && $stable(s_tdata_i) && $stable(s_tlast_i))
   else begin
      fail_count++;
      $error("stream beat changed or dropped before it was accepted");
   end

   // configuration taken only on a quiet bus
   cfg_quiet_bus: assert property (@(posedge clk_i) disable iff (rst_i)
      (cfg_wr_ready_i || cfg_rd_ready_i) |-> hahb_trans_i == TRANS_IDLE && hahb_ready_i)
   else begin
      fail_count++;
      $error("configuration ready while a bus transfer was under way");
   end

   // an accepted configuration leaves the idle state
   cfg_leaves_idle: assert property (@(posedge clk_i) disable iff (rst_i)
      (cfg_wr_ready_i || cfg_rd_ready_i) |=> !cfg_wr_ready_i && !cfg_rd_ready_i)
   else begin
      fail_count++;
      $error("configuration ready again right after a configuration was accepted");
   end

endmodule

/* ahb_stream_top.sv */
`timescale 1ns/10ps
// ========================================
// stream buffer, bridge, memory, stream buffer
// one transfer at a time per configuration
// ========================================
module ahb_stream_top
   import ahb_stream_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_i,
   // write configuration
   input  logic              cfg_wr_valid_i,
   input  logic [ADDR_W-1:0] cfg_wr_addr_i,
   output logic              cfg_wr_ready_o,
   // read configuration
   input  logic              cfg_rd_valid_i,
   input  logic [ADDR_W-1:0] cfg_rd_addr_i,
   input  logic [LEN_W-1:0]  cfg_rd_len_i,
   output logic              cfg_rd_ready_o,
   // input stream
   input  logic              in_tvalid_i,
   input  logic [DATA_W-1:0] in_tdata_i,
   input  logic              in_tlast_i,
   output logic              in_tready_o,
   // output stream
   output logic              out_tvalid_o,
   output logic [DATA_W-1:0] out_tdata_o,
   output logic              out_tlast_o,
   input  logic              out_tready_i
);

   logic              s_tvalid;
   logic [DATA_W-1:0] s_tdata;
   logic              s_tlast;
   logic              s_tready;
   logic              m_tvalid;
   logic [DATA_W-1:0] m_tdata;
   logic              m_tlast;
   logic              m_tready;
   logic [ADDR_W-1:0] hahb_addr;
   logic [1:0]        hahb_trans;
   logic              hahb_write;
   logic [DATA_W-1:0] hahb_wdata;
   logic [STRB_W-1:0] hahb_wstrb;
   logic              hahb_ready;
   logic [DATA_W-1:0] hahb_rdata;

   stream_fifo in_buf (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .in_valid_i (in_tvalid_i),
      .in_data_i  (in_tdata_i),
      .in_last_i  (in_tlast_i),
      .in_ready_o (in_tready_o),
      .out_valid_o(s_tvalid),
      .out_data_o (s_tdata),
      .out_last_o (s_tlast),
      .out_ready_i(s_tready)
   );

   // size and burst are fixed, the memory does not look at them
   axis2ahb adapter (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .cfg_wr_valid_i(cfg_wr_valid_i),
      .cfg_wr_addr_i (cfg_wr_addr_i),
      .cfg_wr_ready_o(cfg_wr_ready_o),
      .cfg_rd_valid_i(cfg_rd_valid_i),
      .cfg_rd_addr_i (cfg_rd_addr_i),
      .cfg_rd_len_i  (cfg_rd_len_i),
      .cfg_rd_ready_o(cfg_rd_ready_o),
      .s_tvalid_i    (s_tvalid),
      .s_tdata_i     (s_tdata),
      .s_tlast_i     (s_tlast),
      .s_tready_o    (s_tready),
      .m_tvalid_o    (m_tvalid),
      .m_tdata_o     (m_tdata),
      .m_tlast_o     (m_tlast),
      .m_tready_i    (m_tready),
      .hahb_addr_o   (hahb_addr),
      .hahb_trans_o  (hahb_trans),
      .hahb_write_o  (hahb_write),
      .hahb_wdata_o  (hahb_wdata),
      .hahb_wstrb_o  (hahb_wstrb),
      .hahb_size_o   (),
      .hahb_burst_o  (),
      .hahb_ready_i  (hahb_ready),
      .hahb_rdata_i  (hahb_rdata)
   );

   ahb_sram sram (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .hahb_addr_i (hahb_addr),
      .hahb_trans_i(hahb_trans),
      .hahb_write_i(hahb_write),
      .hahb_wdata_i(hahb_wdata),
      .hahb_wstrb_i(hahb_wstrb),
      .hahb_ready_o(hahb_ready),
      .hahb_rdata_o(hahb_rdata)
   );

   stream_fifo out_buf (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .in_valid_i (m_tvalid),
      .in_data_i  (m_tdata),
      .in_last_i  (m_tlast),
      .in_ready_o (m_tready),
      .out_valid_o(out_tvalid_o),
      .out_data_o (out_tdata_o),
      .out_last_o (out_tlast_o),
      .out_ready_i(out_tready_i)
   );

endmodule

/* ahb_sram.sv */
`timescale 1ns/10ps
// ========================================
// AHB memory of MEM_WORDS words, address wraps
// WAIT_STATES low ready cycles per data phase
// ========================================
module ahb_sram
   import ahb_stream_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic [ADDR_W-1:0] hahb_addr_i,
   input  logic [1:0]        hahb_trans_i,
   input  logic              hahb_write_i,
   input  logic [DATA_W-1:0] hahb_wdata_i,
   input  logic [STRB_W-1:0] hahb_wstrb_i,
   output logic              hahb_ready_o,
   output logic [DATA_W-1:0] hahb_rdata_o
);

   logic [DATA_W-1:0] mem_q [MEM_WORDS];
   logic [MEM_AW-1:0] idx_q;
   logic              write_q;
   logic              pend_q;
   logic [WAIT_W-1:0] wait_q;
   logic              addr_acc;

   // ready drops only while wait states are counting down
   assign hahb_ready_o = (wait_q == '0);
   assign addr_acc     = hahb_ready_o &&
                         (hahb_trans_i == TRANS_NONSEQ || hahb_trans_i == TRANS_SEQ);
   assign hahb_rdata_o = mem_q[idx_q];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pend_q <= 1'b0;
         wait_q <= '0;
      end else if (addr_acc) begin
         pend_q <= 1'b1;
         wait_q <= WAIT_W'(WAIT_STATES);
      end else begin
         if (hahb_ready_o) begin
            pend_q <= 1'b0;
         end
         if (wait_q != '0) begin
            wait_q <= wait_q - 1'b1;
         end
      end
   end

   // address phase capture, word index modulo the depth
   always_ff @(posedge clk_i) begin
      if (addr_acc) begin
         idx_q   <= hahb_addr_i[ADDR_LSB +: MEM_AW];
         write_q <= hahb_write_i;
      end
   end

   // byte lanes written at the end of a write data phase
   always_ff @(posedge clk_i) begin
      if (pend_q && write_q && hahb_ready_o) begin
         for (int i = 0; i < STRB_W; i++) begin
            if (hahb_wstrb_i[i]) begin
               mem_q[idx_q][8*i +: 8] <= hahb_wdata_i[8*i +: 8];
            end
         end
      end
   end

endmodule

/* axis2ahb.sv */
`timescale 1ns/10ps
// ========================================
// AHB manager fed by a write or read configuration
// cfg_rd_len_i must be 1 or more; no error responses
// reads issue the next beat only after the previous word lands
// ========================================
module axis2ahb
   import ahb_stream_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_i,
   // configuration
   input  logic              cfg_wr_valid_i,
   input  logic [ADDR_W-1:0] cfg_wr_addr_i,
   output logic              cfg_wr_ready_o,
   input  logic              cfg_rd_valid_i,
   input  logic [ADDR_W-1:0] cfg_rd_addr_i,
   input  logic [LEN_W-1:0]  cfg_rd_len_i,
   output logic              cfg_rd_ready_o,
   // stream in and out
   input  logic              s_tvalid_i,
   input  logic [DATA_W-1:0] s_tdata_i,
   input  logic              s_tlast_i,
   output logic              s_tready_o,
   output logic              m_tvalid_o,
   output logic [DATA_W-1:0] m_tdata_o,
   output logic              m_tlast_o,
   input  logic              m_tready_i,
   // AHB manager
   output logic [ADDR_W-1:0] hahb_addr_o,
   output logic [1:0]        hahb_trans_o,
   output logic              hahb_write_o,
   output logic [DATA_W-1:0] hahb_wdata_o,
   output logic [STRB_W-1:0] hahb_wstrb_o,
   output logic [2:0]        hahb_size_o,
   output logic [2:0]        hahb_burst_o,
   input  logic              hahb_ready_i,
   input  logic [DATA_W-1:0] hahb_rdata_i
);

   typedef enum logic [1:0] {
      ST_WAIT_CFG,
      ST_WAIT_DATA,
      ST_TRANSFER,
      ST_LAST_DATA
   } state_t;

   state_t            state_q;
   logic [ADDR_W-1:0] addr_q;
   logic [1:0]        trans_q;
   logic              write_q;
   logic [DATA_W-1:0] wdata_pipe_q;
   logic [STRB_W-1:0] wstrb_pipe_q;
   logic [DATA_W-1:0] wdata_q;
   logic [STRB_W-1:0] wstrb_q;
   logic [LEN_W-1:0]  len_q;
   logic              rd_pend_q;
   logic              idle;
   logic              addr_acc;
   logic              s_take;
   logic              m_take;
   logic              last_word;

   assign idle     = (state_q == ST_WAIT_CFG);
   assign addr_acc = hahb_ready_i && (trans_q == TRANS_NONSEQ || trans_q == TRANS_SEQ);

   // write configuration wins over a read in the same cycle
   assign cfg_wr_ready_o = idle & cfg_wr_valid_i;
   assign cfg_rd_ready_o = idle & cfg_rd_valid_i & ~cfg_wr_valid_i;

   assign s_tready_o = write_q & hahb_ready_i &
                       (state_q == ST_WAIT_DATA || state_q == ST_TRANSFER);
   assign s_take     = s_tvalid_i & s_tready_o;

   // read word goes straight from the bus into the output buffer
   assign last_word  = (len_q == LEN_W'(1));
   assign m_tvalid_o = rd_pend_q & hahb_ready_i;
   assign m_tdata_o  = hahb_rdata_i;
   assign m_tlast_o  = last_word;
   assign m_take     = m_tvalid_o & m_tready_i;

   assign hahb_addr_o  = addr_q;
   assign hahb_trans_o = trans_q;
   assign hahb_write_o = write_q;
   assign hahb_wdata_o = wdata_q;
   assign hahb_wstrb_o = wstrb_q;
   assign hahb_size_o  = HSIZE_WORD;
   assign hahb_burst_o = HBURST_INCR;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q      <= ST_WAIT_CFG;
         trans_q      <= TRANS_IDLE;
         write_q      <= 1'b0;
         wstrb_pipe_q <= '0;
         wstrb_q      <= '0;
         len_q        <= '0;
         rd_pend_q    <= 1'b0;
      end else begin
         if (s_take) begin
            wstrb_pipe_q <= '1;
         end
         // strobes follow their data into the data phase
         if (addr_acc) begin
            wstrb_q   <= wstrb_pipe_q;
            rd_pend_q <= ~write_q;
         end else if (hahb_ready_i) begin
            rd_pend_q <= 1'b0;
         end
         if (m_take) begin
            len_q <= len_q - 1'b1;
         end

         case (state_q)
            ST_WAIT_CFG: begin
               if (cfg_wr_ready_o) begin
                  write_q <= 1'b1;
                  state_q <= ST_WAIT_DATA;
               end else if (cfg_rd_ready_o) begin
                  write_q <= 1'b0;
                  len_q   <= cfg_rd_len_i;
                  state_q <= ST_WAIT_DATA;
               end
            end
            ST_WAIT_DATA: begin
               if (write_q ? s_take : (m_tready_i && hahb_ready_i)) begin
                  trans_q <= TRANS_NONSEQ;
                  state_q <= (write_q && s_tlast_i) ? ST_LAST_DATA : ST_TRANSFER;
               end
            end
            ST_TRANSFER: begin
               if (hahb_ready_i) begin
                  if (write_q) begin
                     // stalled input stream shows BUSY at the held address
                     trans_q <= s_tvalid_i ? TRANS_SEQ : TRANS_BUSY;
                     if (s_tvalid_i && s_tlast_i) begin
                        state_q <= ST_LAST_DATA;
                     end
                  end else if (addr_acc) begin
                     trans_q <= last_word ? TRANS_IDLE : TRANS_BUSY;
                     if (last_word) begin
                        state_q <= ST_LAST_DATA;
                     end
                  end else if (!rd_pend_q && m_tready_i) begin
                     // room downstream for one more word
                     trans_q <= TRANS_SEQ;
                  end
               end
            end
            ST_LAST_DATA: begin
               if (hahb_ready_i) begin
                  if (trans_q != TRANS_IDLE) begin
                     trans_q <= TRANS_IDLE;
                  end else begin
                     // final data phase done
                     write_q      <= 1'b0;
                     wstrb_pipe_q <= '0;
                     wstrb_q      <= '0;
                     state_q      <= ST_WAIT_CFG;
                  end
               end
            end
            default: begin
               state_q <= ST_WAIT_CFG;
            end
         endcase
      end
   end

   // address and write data pipeline
   always_ff @(posedge clk_i) begin
      if (cfg_wr_ready_o) begin
         addr_q <= cfg_wr_addr_i;
      end else if (cfg_rd_ready_o) begin
         addr_q <= cfg_rd_addr_i;
      end else if (addr_acc) begin
         addr_q <= addr_q + ADDR_STEP;
      end
      if (s_take) begin
         wdata_pipe_q <= s_tdata_i;
      end
      if (addr_acc) begin
         wdata_q <= wdata_pipe_q;
      end
   end

endmodule

/* stream_fifo.sv */
`timescale 1ns/10ps
// ========================================
// valid/ready buffer of FIFO_DEPTH beats
// output reads storage directly, one cycle after a push
// ========================================
module stream_fifo
   import ahb_stream_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              in_valid_i,
   input  logic [DATA_W-1:0] in_data_i,
   input  logic              in_last_i,
   output logic              in_ready_o,
   output logic              out_valid_o,
   output logic [DATA_W-1:0] out_data_o,
   output logic              out_last_o,
   input  logic              out_ready_i
);

   logic [DATA_W-1:0]  data_q [FIFO_DEPTH];
   logic               last_q [FIFO_DEPTH];
   logic [FIFO_AW-1:0] wr_ptr_q;
   logic [FIFO_AW-1:0] rd_ptr_q;
   logic [FIFO_AW:0]   count_q;
   logic               push;
   logic               pop;

   // full exactly when the count reaches the power-of-two depth
   assign in_ready_o  = ~count_q[FIFO_AW];
   assign out_valid_o = (count_q != '0);
   assign out_data_o  = data_q[rd_ptr_q];
   assign out_last_o  = last_q[rd_ptr_q];

   assign push = in_valid_i & in_ready_o;
   assign pop  = out_valid_o & out_ready_i;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // push and pop together leave the count alone
         if (push && !pop) begin
            count_q <= count_q + 1'b1;
         end else if (pop && !push) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         data_q[wr_ptr_q] <= in_data_i;
         last_q[wr_ptr_q] <= in_last_i;
      end
   end

endmodule

/* ahb_stream_pkg.sv */
// ========================================
// shared widths and codes for the stream bridge
// FIFO_DEPTH must be a power of two, at least 2
// WAIT_STATES may be 0 or more
// ========================================
package ahb_stream_pkg;

   // bus widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;
   localparam int ADDR_LSB = $clog2(STRB_W);
   localparam logic [ADDR_W-1:0] ADDR_STEP = ADDR_W'(STRB_W);

   // fixed transfer attributes, full word INCR bursts
   localparam logic [2:0] HSIZE_WORD = 3'($clog2(STRB_W));
   localparam logic [2:0] HBURST_INCR = 3'b001;

   // htrans encodings
   localparam logic [1:0] TRANS_IDLE = 2'b00;
   localparam logic [1:0] TRANS_BUSY = 2'b01;
   localparam logic [1:0] TRANS_NONSEQ = 2'b10;
   localparam logic [1:0] TRANS_SEQ = 2'b11;

   // read word count
   localparam int LEN_W = 16;

   // on-chip memory
   localparam int MEM_WORDS = 64;
   localparam int MEM_AW = $clog2(MEM_WORDS);
   localparam int WAIT_STATES = 1;
   localparam int WAIT_W = $clog2(WAIT_STATES + 2);

   // stream buffers
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_AW = $clog2(FIFO_DEPTH);

endpackage
